// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_line_burst_adapter
SEED      ?= 1
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --timing -sv -Wno-fatal --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/burst_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_mem_model #(
    parameter int          addr_width = 32,
    parameter logic [63:0] init_mix   = 64'h0
) (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic [addr_width-1:0]            bmem_addr,
    input  wire logic                             bmem_read,
    input  wire logic                             bmem_write,
    input  wire logic [burst_pkg::beat_bits-1:0]  bmem_wdata,
    output logic                                  bmem_ready,
    output logic                                  bmem_rvalid,
    output logic [addr_width-1:0]                 bmem_raddr,
    output logic [burst_pkg::beat_bits-1:0]       bmem_rdata,
    output logic                                  log_valid,
    output logic [addr_width-1:0]                 log_addr,
    output logic [burst_pkg::beat_bits-1:0]       log_data
);

    logic [burst_pkg::beat_bits-1:0] mem [logic [addr_width-1:0]];   // keyed by word address.
    logic [addr_width-1:0]           pending [$];
    logic [addr_width-1:0]           rd_line;
    int                              wr_beat;
    int                              rd_beat;
    int                              rd_delay;
    logic                            rd_active;
    logic                            stray;

    // contents of a word that was never written.
    function automatic logic [63:0] init_word(input logic [addr_width-1:0] a);
        return (64'(a) * 64'h9e37_79b9_7f4a_7c15) ^ init_mix;
    endfunction

    function automatic logic [63:0] word_at(input logic [addr_width-1:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return init_word(a);
    endfunction

    initial begin
        bmem_ready  = 1'b0;
        bmem_rvalid = 1'b0;
        bmem_raddr  = '0;
        bmem_rdata  = '0;
        log_valid   = 1'b0;
        log_addr    = '0;
        log_data    = '0;
        rd_active   = 1'b0;
        stray       = 1'b0;
        wr_beat     = 0;
    end

    // commands and write beats, taken mid cycle.
    always @(negedge clk) begin
        log_valid = 1'b0;
        if (rst) begin
            wr_beat = 0;
            pending.delete();
        end else begin
            if (bmem_write && bmem_ready) begin
                mem[bmem_addr + addr_width'(wr_beat * 8)] = bmem_wdata;
                log_valid = 1'b1;
                log_addr  = bmem_addr;
                log_data  = bmem_wdata;
                wr_beat   = (wr_beat + 1) % burst_pkg::beats_per_line;
            end
            if (bmem_read && bmem_ready) begin
                pending.push_back(bmem_addr);
            end
        end
    end

    // ready stalls and read beat return.
    always @(posedge clk) begin
        #2;
        bmem_rvalid = 1'b0;
        if (rst) begin
            bmem_ready = 1'b0;
            rd_active  = 1'b0;
        end else begin
            bmem_ready = ($urandom % 3) != 0;   // stall about one cycle in three.
            if (!rd_active) begin
                if (pending.size() > 0) begin
                    rd_line   = pending.pop_front();
                    rd_delay  = 1 + $urandom % 6;
                    rd_beat   = 0;
                    stray     = ($urandom % 4) == 0;
                    rd_active = 1'b1;
                end
            end else if (rd_delay > 0) begin
                rd_delay--;
            end else if (stray) begin
                bmem_rvalid = 1'b1;
                bmem_raddr  = rd_line ^ addr_width'(32'h20);   // neighbour line.
                bmem_rdata  = {$urandom, $urandom};
                stray       = 1'b0;
            end else if ($urandom % 4 != 0) begin
                bmem_rvalid = 1'b1;
                bmem_raddr  = rd_line;
                bmem_rdata  = word_at(rd_line + addr_width'(rd_beat * 8));
                rd_beat++;
                rd_active   = rd_beat < burst_pkg::beats_per_line;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/tb_line_burst_adapter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_line_burst_adapter;

    localparam int          addr_width = 32;
    localparam logic [63:0] init_mix   = 64'h5a5a_c3c3_0f1e_2d3c;
    localparam int          n_random   = 200;
    localparam int          wait_limit = 400;

    logic                            clk;
    logic                            rst;
    logic                            dfp_req;
    logic                            dfp_write;
    logic [addr_width-1:0]           dfp_addr;
    logic [burst_pkg::line_bits-1:0] dfp_wdata;
    logic                            dfp_ack;
    logic [burst_pkg::line_bits-1:0] dfp_rdata;
    logic                            bmem_ready;
    logic [addr_width-1:0]           bmem_addr;
    logic                            bmem_read;
    logic                            bmem_write;
    logic [burst_pkg::beat_bits-1:0] bmem_wdata;
    logic                            bmem_rvalid;
    logic [addr_width-1:0]           bmem_raddr;
    logic [burst_pkg::beat_bits-1:0] bmem_rdata;
    logic                            log_valid;
    logic [addr_width-1:0]           log_addr;
    logic [burst_pkg::beat_bits-1:0] log_data;

    logic [burst_pkg::line_bits-1:0] shadow [logic [addr_width-1:0]];
    logic [addr_width-1:0]           beat_addr_q [$];
    logic [burst_pkg::beat_bits-1:0] beat_data_q [$];
    int                              n_sent    = 0;
    int                              n_checked = 0;
    logic                            ack_q     = 1'b0;
    logic                            req_q     = 1'b0;

    line_burst_adapter #(.addr_width(addr_width)) i_line_burst_adapter (
        .clk(clk), .rst(rst),
        .dfp_req(dfp_req), .dfp_write(dfp_write), .dfp_addr(dfp_addr),
        .dfp_wdata(dfp_wdata), .dfp_ack(dfp_ack), .dfp_rdata(dfp_rdata),
        .bmem_ready(bmem_ready), .bmem_addr(bmem_addr), .bmem_read(bmem_read),
        .bmem_write(bmem_write), .bmem_wdata(bmem_wdata), .bmem_rvalid(bmem_rvalid),
        .bmem_raddr(bmem_raddr), .bmem_rdata(bmem_rdata)
    );

    burst_mem_model #(.addr_width(addr_width), .init_mix(init_mix)) i_burst_mem_model (
        .clk(clk), .rst(rst),
        .bmem_addr(bmem_addr), .bmem_read(bmem_read), .bmem_write(bmem_write),
        .bmem_wdata(bmem_wdata), .bmem_ready(bmem_ready), .bmem_rvalid(bmem_rvalid),
        .bmem_raddr(bmem_raddr), .bmem_rdata(bmem_rdata),
        .log_valid(log_valid), .log_addr(log_addr), .log_data(log_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [63:0] init_word(input logic [addr_width-1:0] a);
        return (64'(a) * 64'h9e37_79b9_7f4a_7c15) ^ init_mix;
    endfunction

    // last line written there, else the untouched memory words.
    function automatic logic [burst_pkg::line_bits-1:0] expected_line(
        input logic [addr_width-1:0] line_addr);
        logic [burst_pkg::line_bits-1:0] words;
        if (shadow.exists(line_addr)) begin
            return shadow[line_addr];
        end
        for (int k = 0; k < burst_pkg::beats_per_line; k++) begin
            words[k*64 +: 64] = init_word(line_addr + addr_width'(k * 8));
        end
        return words;
    endfunction

    function automatic logic [burst_pkg::line_bits-1:0] random_line();
        logic [burst_pkg::line_bits-1:0] data;
        for (int k = 0; k < burst_pkg::line_bits / 32; k++) begin
            data[k*32 +: 32] = $urandom;
        end
        return data;
    endfunction

    task automatic report_failure(input string what);
        $display("at %0t ns: %s", $time, what);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_line(input string name, input logic [burst_pkg::line_bits-1:0] exp,
                              input logic [burst_pkg::line_bits-1:0] act);
        if (act !== exp) begin
            $display("ERROR at %0t ns: %s expected %h actual %h", $time, name, exp, act);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic check_beat(input string name, input logic [burst_pkg::beat_bits-1:0] exp,
                              input logic [burst_pkg::beat_bits-1:0] act);
        if (act !== exp) begin
            $display("ERROR at %0t ns: %s expected %h actual %h", $time, name, exp, act);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic check_addr(input string name, input logic [addr_width-1:0] exp,
                              input logic [addr_width-1:0] act);
        if (act !== exp) begin
            $display("ERROR at %0t ns: %s expected %h actual %h", $time, name, exp, act);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR at %0t ns: %s expected %b actual %b", $time, name, exp, act);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // one four-phase handshake, entered and left 2 ns after a rising edge.
    task automatic run_request(input logic wr, input logic [addr_width-1:0] addr,
                               input logic [burst_pkg::line_bits-1:0] data);
        int cycles;
        dfp_write = wr;
        dfp_addr  = addr;
        dfp_wdata = data;
        dfp_req   = 1'b1;
        n_sent++;
        cycles = 0;
        while (dfp_ack !== 1'b1) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > wait_limit) report_failure("dfp_ack never rose for the request");
        end
        @(posedge clk);   // let the compare process see the line first.
        #2;
        dfp_req = 1'b0;
        cycles  = 0;
        while (dfp_ack !== 1'b0) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > wait_limit) report_failure("dfp_ack stayed high after dfp_req fell");
        end
    endtask

    always @(posedge clk) begin
        if (log_valid) begin
            beat_addr_q.push_back(log_addr);
            beat_data_q.push_back(log_data);
        end
    end

    // handshake rules.
    always @(negedge clk) begin
        if (!rst) begin
            if (dfp_ack && !ack_q && !dfp_req) report_failure("dfp_ack rose with dfp_req low");
            if (!dfp_ack && ack_q && req_q) report_failure("dfp_ack fell with dfp_req high");
            if (dfp_ack && ack_q && !req_q) begin
                report_failure("dfp_ack still high one cycle after dfp_req fell");
            end
        end
        ack_q <= dfp_ack;
        req_q <= dfp_req;
    end

    always @(negedge clk) begin : compare_proc
        logic [addr_width-1:0] line_addr;
        if (!rst && dfp_ack && !ack_q) begin
            line_addr = {dfp_addr[addr_width-1:5], 5'b0};
            if (dfp_write) begin
                if (beat_addr_q.size() != burst_pkg::beats_per_line) begin
                    report_failure("write burst did not log exactly four beats");
                end
                for (int k = 0; k < burst_pkg::beats_per_line; k++) begin
                    check_addr("bmem_addr", line_addr, beat_addr_q[k]);
                    check_beat("bmem_wdata", dfp_wdata[k*64 +: 64], beat_data_q[k]);
                end
                shadow[line_addr] = dfp_wdata;
            end else begin
                if (beat_addr_q.size() != 0) report_failure("read request produced write beats");
                check_line("dfp_rdata", expected_line(line_addr), dfp_rdata);
            end
            beat_addr_q.delete();
            beat_data_q.delete();
            n_checked++;
        end
    end

    initial begin
        logic [addr_width-1:0]           addr;
        logic [burst_pkg::line_bits-1:0] data;
        int                              gap;
        void'($urandom(32'h24af_95e9));
        rst       = 1'b1;
        dfp_req   = 1'b0;
        dfp_write = 1'b0;
        dfp_addr  = '0;
        dfp_wdata = '0;
        for (int i = 0; i < 17; i++) begin
            @(posedge clk);
            #2;
            rst = i < 15;   // high over the first 16 edges.
            check_bit("dfp_ack", 1'b0, dfp_ack);
            check_bit("bmem_read", 1'b0, bmem_read);
            check_bit("bmem_write", 1'b0, bmem_write);
        end

        data = random_line();
        run_request(1'b1, 32'h0001_0013, data);   // unaligned, lands on line 0001_0000.
        run_request(1'b0, 32'h0001_0000, '0);
        run_request(1'b0, 32'h0002_0040, '0);     // never written.

        for (int n = 0; n < n_random; n++) begin
            addr = addr_width'(32'h0001_0000 + (($urandom % 16) << 5) + ($urandom % 32));
            run_request(1'($urandom % 2), addr, random_line());
            gap = $urandom % 3;
            repeat (gap) begin
                @(posedge clk);
                #2;
            end
        end

        repeat (4) @(posedge clk);
        if (n_checked != n_sent) begin
            report_failure("not every request reached the compare process");
        end else begin
            $display("%0d requests checked", n_checked);
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== design/burst_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_issue #(
    parameter int addr_width = 32
) (
    input  wire logic                             clk,
    input  wire logic                             rst,

    input  wire logic                             cmd_start,
    input  wire burst_pkg::line_op_e              cmd_op,
    input  wire logic [addr_width-1:0]            cmd_addr,
    input  wire logic [burst_pkg::line_bits-1:0]  cmd_wdata,

    input  wire logic                             bmem_ready,
    output logic [addr_width-1:0]                 bmem_addr,
    output logic                                  bmem_read,
    output logic                                  bmem_write,
    output logic [burst_pkg::beat_bits-1:0]       bmem_wdata,

    output logic                                  rd_arm,
    output logic [addr_width-1:0]                 rd_addr,
    input  wire logic                             line_done,
    output logic                                  op_done
);

    localparam int cnt_bits = $clog2(burst_pkg::beats_per_line);
    localparam logic [cnt_bits-1:0] last_beat = cnt_bits'(burst_pkg::beats_per_line - 1);

    burst_pkg::issue_state_e state;
    burst_pkg::issue_state_e state_next;
    logic [cnt_bits-1:0]     beat_cnt;
    logic                    beat_accept;

    assign beat_accept = (state == burst_pkg::st_write_beat) && bmem_ready;

    always_comb begin
        state_next = state;
        case (state)
            burst_pkg::st_idle: begin
                if (cmd_start) begin
                    if (cmd_op == burst_pkg::op_write) begin
                        state_next = burst_pkg::st_write_beat;
                    end else begin
                        state_next = burst_pkg::st_read_cmd;
                    end
                end
            end
            burst_pkg::st_read_cmd: begin
                if (bmem_ready) begin
                    state_next = burst_pkg::st_read_wait;
                end
            end
            burst_pkg::st_read_wait: begin
                if (line_done) begin
                    state_next = burst_pkg::st_done;
                end
            end
            burst_pkg::st_write_beat: begin
                if (beat_accept && beat_cnt == last_beat) begin
                    state_next = burst_pkg::st_done;
                end
            end
            burst_pkg::st_done: state_next = burst_pkg::st_idle;
            default:            state_next = burst_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= burst_pkg::st_idle;
            beat_cnt <= '0;
        end else begin
            state <= state_next;
            if (cmd_start) begin
                beat_cnt <= '0;
            end else if (beat_accept) begin
                beat_cnt <= beat_cnt + 1'b1;   // wraps to zero after the last beat.
            end
        end
    end

    // command outputs are decoded from the state alone.
    assign bmem_addr  = cmd_addr;
    assign bmem_read  = (state == burst_pkg::st_read_cmd);
    assign bmem_write = (state == burst_pkg::st_write_beat);
    assign bmem_wdata = cmd_wdata[beat_cnt * burst_pkg::beat_bits +: burst_pkg::beat_bits];

    // assembler is armed in the cycle the read command is taken.
    assign rd_arm  = bmem_read && bmem_ready;
    assign rd_addr = cmd_addr;

    assign op_done = (state == burst_pkg::st_done);

endmodule

`default_nettype wire

// ==== design/burst_pkg.sv ====
`default_nettype none

package burst_pkg;

    // memory side beat and cache side line.
    parameter int beat_bits      = 64;
    parameter int beats_per_line = 4;
    parameter int line_bits      = beat_bits * beats_per_line;

    // operation carried by one cache request.
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } line_op_e;

    // burst sequencer states.
    typedef enum logic [2:0] {
        st_idle       = 3'd0,   // waiting for cmd_start.
        st_read_cmd   = 3'd1,   // read command held until ready.
        st_read_wait  = 3'd2,   // beats being collected.
        st_write_beat = 3'd3,   // one write beat per accept.
        st_done       = 3'd4    // op_done cycle.
    } issue_state_e;

endpackage

`default_nettype wire

// ==== design/line_assembler.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_assembler #(
    parameter int addr_width = 32
) (
    input  wire logic                             clk,
    input  wire logic                             rst,

    input  wire logic                             rd_arm,
    input  wire logic [addr_width-1:0]            rd_addr,

    input  wire logic                             bmem_rvalid,
    input  wire logic [addr_width-1:0]            bmem_raddr,
    input  wire logic [burst_pkg::beat_bits-1:0]  bmem_rdata,

    output logic [burst_pkg::line_bits-1:0]       line_data,
    output logic                                  line_done
);

    localparam int cnt_bits = $clog2(burst_pkg::beats_per_line);
    localparam logic [cnt_bits-1:0] last_beat = cnt_bits'(burst_pkg::beats_per_line - 1);
    localparam int acc_bits = burst_pkg::line_bits - burst_pkg::beat_bits;

    logic                  armed;
    logic [addr_width-1:0] arm_addr;
    logic [cnt_bits-1:0]   beat_cnt;
    logic [acc_bits-1:0]   acc;         // beats before the last, oldest lowest.
    logic                  beat_hit;

    // stray beats for other lines are dropped here.
    assign beat_hit = armed && bmem_rvalid && (bmem_raddr == arm_addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            armed     <= 1'b0;
            beat_cnt  <= '0;
            line_done <= 1'b0;
        end else begin
            line_done <= 1'b0;
            if (rd_arm) begin
                armed    <= 1'b1;
                beat_cnt <= '0;
            end else if (beat_hit) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (beat_cnt == last_beat) begin
                    armed     <= 1'b0;
                    line_done <= 1'b1;
                end
            end
        end
    end

    // line payload path.
    always_ff @(posedge clk) begin
        if (rd_arm) begin
            arm_addr <= rd_addr;
        end
        if (beat_hit) begin
            if (beat_cnt == last_beat) begin
                line_data <= {bmem_rdata, acc};
            end else begin
                // shift down so beat 0 ends in the low slot.
                acc <= {bmem_rdata, acc[acc_bits-1:burst_pkg::beat_bits]};
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/line_burst_adapter.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_burst_adapter #(
    parameter int addr_width = 32
) (
    input  wire logic                             clk,
    input  wire logic                             rst,

    input  wire logic                             dfp_req,
    input  wire logic                             dfp_write,
    input  wire logic [addr_width-1:0]            dfp_addr,
    input  wire logic [burst_pkg::line_bits-1:0]  dfp_wdata,
    output logic                                  dfp_ack,
    output logic [burst_pkg::line_bits-1:0]       dfp_rdata,

    input  wire logic                             bmem_ready,
    output logic [addr_width-1:0]                 bmem_addr,
    output logic                                  bmem_read,
    output logic                                  bmem_write,
    output logic [burst_pkg::beat_bits-1:0]       bmem_wdata,
    input  wire logic                             bmem_rvalid,
    input  wire logic [addr_width-1:0]            bmem_raddr,
    input  wire logic [burst_pkg::beat_bits-1:0]  bmem_rdata
);

    logic                             cmd_start;
    burst_pkg::line_op_e              cmd_op;
    logic [addr_width-1:0]            cmd_addr;
    logic [burst_pkg::line_bits-1:0]  cmd_wdata;
    logic                             op_done;
    logic                             rd_arm;
    logic [addr_width-1:0]            rd_addr;
    logic                             line_done;

    line_request_decode #(
        .addr_width (addr_width)
    ) i_line_request_decode (
        .clk        (clk),
        .rst        (rst),
        .dfp_req    (dfp_req),
        .dfp_write  (dfp_write),
        .dfp_addr   (dfp_addr),
        .dfp_wdata  (dfp_wdata),
        .dfp_ack    (dfp_ack),
        .op_done    (op_done),
        .cmd_start  (cmd_start),
        .cmd_op     (cmd_op),
        .cmd_addr   (cmd_addr),
        .cmd_wdata  (cmd_wdata)
    );

    burst_issue #(
        .addr_width (addr_width)
    ) i_burst_issue (
        .clk        (clk),
        .rst        (rst),
        .cmd_start  (cmd_start),
        .cmd_op     (cmd_op),
        .cmd_addr   (cmd_addr),
        .cmd_wdata  (cmd_wdata),
        .bmem_ready (bmem_ready),
        .bmem_addr  (bmem_addr),
        .bmem_read  (bmem_read),
        .bmem_write (bmem_write),
        .bmem_wdata (bmem_wdata),
        .rd_arm     (rd_arm),
        .rd_addr    (rd_addr),
        .line_done  (line_done),
        .op_done    (op_done)
    );

    line_assembler #(
        .addr_width (addr_width)
    ) i_line_assembler (
        .clk         (clk),
        .rst         (rst),
        .rd_arm      (rd_arm),
        .rd_addr     (rd_addr),
        .bmem_rvalid (bmem_rvalid),
        .bmem_raddr  (bmem_raddr),
        .bmem_rdata  (bmem_rdata),
        .line_data   (dfp_rdata),
        .line_done   (line_done)
    );

endmodule

`default_nettype wire

// ==== design/line_request_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_request_decode #(
    parameter int addr_width = 32
) (
    input  wire logic                             clk,
    input  wire logic                             rst,

    input  wire logic                             dfp_req,
    input  wire logic                             dfp_write,
    input  wire logic [addr_width-1:0]            dfp_addr,
    input  wire logic [burst_pkg::line_bits-1:0]  dfp_wdata,
    output logic                                  dfp_ack,

    input  wire logic                             op_done,
    output logic                                  cmd_start,
    output burst_pkg::line_op_e                   cmd_op,
    output logic [addr_width-1:0]                 cmd_addr,
    output logic [burst_pkg::line_bits-1:0]       cmd_wdata
);

    // byte offset bits inside one line.
    localparam int offset_bits = $clog2(burst_pkg::line_bits / 8);

    logic req_q;
    logic busy;
    logic new_req;

    // rising req, nothing in flight and the last ack already dropped.
    assign new_req = dfp_req && !req_q && !busy && !dfp_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q     <= 1'b0;
            busy      <= 1'b0;
            cmd_start <= 1'b0;
            dfp_ack   <= 1'b0;
        end else begin
            req_q     <= dfp_req;
            cmd_start <= new_req;
            if (new_req) begin
                busy <= 1'b1;
            end else if (op_done) begin
                busy <= 1'b0;
            end
            if (op_done) begin
                dfp_ack <= 1'b1;
            end else if (dfp_ack && !dfp_req) begin
                dfp_ack <= 1'b0;   // requester has let go.
            end
        end
    end

    // request payload, held until the next capture.
    always_ff @(posedge clk) begin
        if (new_req) begin
            cmd_addr  <= {dfp_addr[addr_width-1:offset_bits], {offset_bits{1'b0}}};
            cmd_wdata <= dfp_wdata;
            cmd_op    <= dfp_write ? burst_pkg::op_write : burst_pkg::op_read;
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
design/burst_pkg.sv
design/line_request_decode.sv
design/burst_issue.sv
design/line_assembler.sv
design/line_burst_adapter.sv
bench/burst_mem_model.sv
bench/tb_line_burst_adapter.sv
